//--- systolic_gemm_top.f
common/systolic_pkg.sv
pe_array/systolic_pe.sv
pe_array/pe_array.sv
verilog/weight_fifo.sv
verilog/run_counter.sv
verilog/gemm_sequencer.sv
verilog/systolic_gemm_top.sv
tb/systolic_gemm_checker.sv
tb/tb_systolic_gemm.sv

//--- Bender.yml
package:
  name: systolic_gemm

sources:
  - common/systolic_pkg.sv
  - pe_array/systolic_pe.sv
  - pe_array/pe_array.sv
  - verilog/weight_fifo.sv
  - verilog/run_counter.sv
  - verilog/gemm_sequencer.sv
  - verilog/systolic_gemm_top.sv
  - target: test
    files:
      - tb/systolic_gemm_checker.sv
      - tb/tb_systolic_gemm.sv

//--- tb/tb_systolic_gemm.sv
// Directed tests only; every run pops exactly ARRAY_DIM rows, so the FIFO is empty between tests
`default_nettype none

module tb_systolic_gemm;

    localparam int MAX_WAIT = 200;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      start;
    systolic_pkg::run_cfg_t    cfg;
    logic                      weight_wr_en;
    systolic_pkg::vec_t        weight_wr_data;
    logic                      weight_fifo_full;
    logic                      act_valid;
    systolic_pkg::vec_t        act_data;
    logic                      act_ready;
    systolic_pkg::result_vec_t result_data;
    logic                      result_valid;
    logic                      busy;
    logic                      done;

    // Weight matrix, row r sits in element r
    systolic_pkg::vec_t [systolic_pkg::ARRAY_DIM-1:0] weights;
    systolic_pkg::vec_t        acts [$];
    systolic_pkg::result_vec_t got [$];
    logic [15:0]               lfsr;

    // Clock count when each vector is offered and when each result is seen
    int                        cycle_cnt = 0;
    int                        issue_cyc [$];
    int                        result_cyc [$];

    systolic_gemm_top i_systolic_gemm_top (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .cfg              (cfg),
        .weight_wr_en     (weight_wr_en),
        .weight_wr_data   (weight_wr_data),
        .weight_fifo_full (weight_fifo_full),
        .act_valid        (act_valid),
        .act_data         (act_data),
        .act_ready        (act_ready),
        .result_data      (result_data),
        .result_valid     (result_valid),
        .busy             (busy),
        .done             (done)
    );

    initial begin
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Outputs are all registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (result_valid === 1'b1) begin
            got.push_back(result_data);
            result_cyc.push_back(cycle_cnt);
        end
    end

    // ------------------------------------------------------------------
    // Random data and reference model
    // ------------------------------------------------------------------
    // Taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_vec(output systolic_pkg::vec_t v);
        systolic_pkg::elem_t e;
        for (int c = 0; c < systolic_pkg::ARRAY_DIM; c++) begin
            for (int i = 0; i < systolic_pkg::DATA_WIDTH; i++) begin
                lfsr = lfsr_next(lfsr);
                e = {e[systolic_pkg::DATA_WIDTH-2:0], lfsr[0]};
            end
            v[c] = e;
        end
    endtask

    // Column sums in row order, clamped after every addition
    function automatic systolic_pkg::result_vec_t model_result(
        input systolic_pkg::vec_t [systolic_pkg::ARRAY_DIM-1:0] w,
        input systolic_pkg::vec_t                               a
    );
        systolic_pkg::result_vec_t res;
        systolic_pkg::elem_t       we;
        systolic_pkg::elem_t       ae;
        longint                    acc;
        for (int c = 0; c < systolic_pkg::ARRAY_DIM; c++) begin
            acc = 0;
            for (int r = 0; r < systolic_pkg::ARRAY_DIM; r++) begin
                we  = w[r][c];
                ae  = a[r];
                acc = acc + longint'(we) * longint'(ae);
                if (acc > 64'sd2147483647) begin
                    acc = 64'sd2147483647;
                end else if (acc < -64'sd2147483648) begin
                    acc = -64'sd2147483648;
                end
            end
            res[c] = acc[31:0];
        end
        return res;
    endfunction

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Simulation stopped at first failure");
    endtask

    task automatic check_result(input string name, input systolic_pkg::result_vec_t got_v,
                                input systolic_pkg::result_vec_t exp_v);
        if (got_v !== exp_v) begin
            fail_with($sformatf("Mismatch %s: got %h expected %h", name, got_v, exp_v));
        end
    endtask

    task automatic check_bit(input string name, input logic got_v, input logic exp_v);
        if (got_v !== exp_v) begin
            fail_with($sformatf("Mismatch %s: got %h expected %h", name, got_v, exp_v));
        end
    endtask

    // ------------------------------------------------------------------
    // Drivers that start and end on a falling edge
    // ------------------------------------------------------------------
    task automatic clear_run();
        got.delete();
        acts.delete();
        issue_cyc.delete();
        result_cyc.delete();
    endtask

    task automatic push_rows(input int first, input int last);
        for (int r = first; r <= last; r++) begin
            weight_wr_en   = 1'b1;
            weight_wr_data = weights[r];
            @(negedge clk);
        end
        weight_wr_en = 1'b0;
    endtask

    task automatic start_run(input logic [systolic_pkg::MODE_WIDTH-1:0] mode,
                             input logic [systolic_pkg::NUM_VEC_WIDTH-1:0] num,
                             input logic expect_busy);
        start           = 1'b1;
        cfg.mode        = mode;
        cfg.num_vectors = num;
        @(negedge clk);
        start = 1'b0;
        check_bit("busy", busy, expect_busy);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (act_ready !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > MAX_WAIT) begin
                fail_with("Timeout while waiting for act_ready");
            end
        end
    endtask

    // Each vector is offered only with act_ready high, so it is taken at the next edge
    task automatic send_vectors(input int gap);
        foreach (acts[i]) begin
            wait_ready();
            issue_cyc.push_back(cycle_cnt);
            act_valid = 1'b1;
            act_data  = acts[i];
            @(negedge clk);
            if (gap > 0) begin
                act_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
        end
        act_valid = 1'b0;
    endtask

    // Waits for done, then compares every result and its latency against the model
    task automatic finish_run();
        systolic_pkg::result_vec_t exp_v;
        int n;
        int lat;
        n = 0;
        while (done !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > MAX_WAIT) begin
                fail_with("Timeout while waiting for done");
            end
        end
        if (got.size() != acts.size()) begin
            fail_with($sformatf("Expected %0d results before done but saw %0d",
                                acts.size(), got.size()));
        end
        foreach (acts[i]) begin
            exp_v = model_result(weights, acts[i]);
            check_result($sformatf("result_data[%0d]", i), got[i], exp_v);
            lat = result_cyc[i] - issue_cyc[i];
            if (lat != systolic_pkg::PIPE_LATENCY) begin
                fail_with($sformatf("Result %0d came %0d cycles after its vector instead of %0d",
                                    i, lat, systolic_pkg::PIPE_LATENCY));
            end
        end
        @(negedge clk);
        check_bit("done", done, 1'b0);
        check_bit("busy", busy, 1'b0);
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    task automatic test_basic_product();
        clear_run();
        for (int r = 0; r < systolic_pkg::ARRAY_DIM; r++) begin
            for (int c = 0; c < systolic_pkg::ARRAY_DIM; c++) begin
                weights[r][c] = (r == c) ? systolic_pkg::elem_t'(r + 1) : '0;
            end
        end
        weights[3][0] = -8'sd1;
        acts.push_back({8'sd4, -8'sd3, 8'sd2, 8'sd1});
        acts.push_back({-8'sd128, 8'sd127, 8'sd0, -8'sd5});
        acts.push_back({8'sd10, 8'sd20, 8'sd30, 8'sd40});
        push_rows(0, systolic_pkg::ARRAY_DIM - 1);
        start_run(systolic_pkg::MODE_GEMM, 16'd3, 1'b1);
        send_vectors(1);
        finish_run();
    endtask

    // Extreme operands at both ends of the element range
    task automatic test_saturation();
        clear_run();
        for (int r = 0; r < systolic_pkg::ARRAY_DIM; r++) begin
            for (int c = 0; c < systolic_pkg::ARRAY_DIM; c++) begin
                weights[r][c] = (c % 2 == 0) ? -8'sd128 : 8'sd127;
            end
        end
        acts.push_back(32'h80808080);
        acts.push_back(32'h7F7F7F7F);
        acts.push_back(32'h7F807F80);
        push_rows(0, systolic_pkg::ARRAY_DIM - 1);
        start_run(systolic_pkg::MODE_GEMM, 16'd3, 1'b1);
        send_vectors(0);
        finish_run();
    endtask

    task automatic test_weight_stall();
        systolic_pkg::vec_t v;
        clear_run();
        for (int r = 0; r < systolic_pkg::ARRAY_DIM; r++) begin
            random_vec(v);
            weights[r] = v;
        end
        for (int i = 0; i < 2; i++) begin
            random_vec(v);
            acts.push_back(v);
        end
        start_run(systolic_pkg::MODE_GEMM, 16'd2, 1'b1);
        // Offered while loading, must be dropped
        act_valid = 1'b1;
        act_data  = 32'h5A5A5A5A;
        repeat (5) begin
            @(negedge clk);
            check_bit("act_ready", act_ready, 1'b0);
        end
        push_rows(0, 1);
        repeat (4) begin
            @(negedge clk);
            check_bit("act_ready", act_ready, 1'b0);
        end
        act_valid = 1'b0;
        push_rows(2, 2);
        check_bit("act_ready", act_ready, 1'b0);
        push_rows(3, 3);
        send_vectors(0);
        finish_run();
    endtask

    task automatic test_streaming();
        systolic_pkg::vec_t v;
        clear_run();
        for (int r = 0; r < systolic_pkg::ARRAY_DIM; r++) begin
            random_vec(v);
            weights[r] = v;
        end
        for (int i = 0; i < 12; i++) begin
            random_vec(v);
            acts.push_back(v);
        end
        push_rows(0, systolic_pkg::ARRAY_DIM - 1);
        start_run(systolic_pkg::MODE_GEMM, 16'd12, 1'b1);
        send_vectors(0);
        finish_run();
    endtask

    task automatic test_mode_idle_fifo();
        clear_run();
        check_bit("act_ready", act_ready, 1'b0);
        act_valid = 1'b1;
        act_data  = 32'h01020304;
        repeat (3) @(negedge clk);
        act_valid = 1'b0;
        repeat (systolic_pkg::PIPE_LATENCY + 2) @(negedge clk);
        if (got.size() != 0) begin
            fail_with("A result came out for an activation offered while idle");
        end
        start_run(4'h3, 16'd4, 1'b0);
        start_run(systolic_pkg::MODE_GEMM, 16'd0, 1'b0);
        @(negedge clk);
        check_bit("busy", busy, 1'b0);
        push_rows(0, systolic_pkg::ARRAY_DIM - 1);
        check_bit("weight_fifo_full", weight_fifo_full, 1'b0);
        for (int i = 1; i < systolic_pkg::WEIGHT_FIFO_DEPTH / systolic_pkg::ARRAY_DIM; i++) begin
            push_rows(0, systolic_pkg::ARRAY_DIM - 1);
        end
        check_bit("weight_fifo_full", weight_fifo_full, 1'b1);
    endtask

    initial begin
        rst_n          = 1'b0;
        start          = 1'b0;
        cfg            = '0;
        weight_wr_en   = 1'b0;
        weight_wr_data = '0;
        act_valid      = 1'b0;
        act_data       = '0;
        weights        = '0;
        lfsr           = 16'd17110;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("act_ready", act_ready, 1'b0);
        check_bit("result_valid", result_valid, 1'b0);
        check_bit("weight_fifo_full", weight_fifo_full, 1'b0);
        test_basic_product();
        test_saturation();
        test_weight_stall();
        test_streaming();
        test_mode_idle_fifo();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/systolic_gemm_checker.sv
// Assertions are off while rst_n is low; state comes from the sequencer by hierarchical path
`default_nettype none

module systolic_gemm_checker (
    input wire                       clk,
    input wire                       rst_n,
    input wire                       done,
    input wire                       result_valid,
    input wire                       act_ready,
    input wire                       busy,
    input wire systolic_pkg::state_t state
);

    // Done is a single pulse that returns the engine to IDLE
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> (!done && (state == systolic_pkg::IDLE)))
        else $error("done held longer than one cycle");

    a_result_busy: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> busy)
        else $error("result_valid seen while not busy");

    a_ready_busy: assert property (@(posedge clk) disable iff (!rst_n)
        act_ready |-> busy)
        else $error("act_ready seen while not busy");

    a_done_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !(done && act_ready))
        else $error("done and act_ready high together");

endmodule

bind systolic_gemm_top systolic_gemm_checker i_systolic_gemm_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .done         (done),
    .result_valid (result_valid),
    .act_ready    (act_ready),
    .busy         (busy),
    .state        (i_gemm_sequencer.state_q)
);

`default_nettype wire

//--- verilog/systolic_gemm_top.sv
// No back-pressure on results; act_valid is only taken while act_ready is high
`default_nettype none

module systolic_gemm_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start,
    input  wire systolic_pkg::run_cfg_t cfg,
    input  wire                         weight_wr_en,
    input  wire systolic_pkg::vec_t     weight_wr_data,
    output logic                        weight_fifo_full,
    input  wire                         act_valid,
    input  wire systolic_pkg::vec_t     act_data,
    output logic                        act_ready,
    output systolic_pkg::result_vec_t   result_data,
    output logic                        result_valid,
    output logic                        busy,
    output logic                        done
);

    wire systolic_pkg::vec_t     head_row;
    wire systolic_pkg::row_idx_t row_idx;
    wire fifo_empty;
    wire fifo_pop;
    wire run_start;
    wire rows_loaded;
    wire issue_done;
    wire retire_done;
    wire act_issue;

    // Vectors offered outside COMPUTE are dropped here
    assign act_issue = act_valid && act_ready;

    weight_fifo i_weight_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (weight_wr_en),
        .push_row (weight_wr_data),
        .full     (weight_fifo_full),
        .pop      (fifo_pop),
        .head_row (head_row),
        .empty    (fifo_empty)
    );

    gemm_sequencer i_gemm_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .cfg         (cfg),
        .fifo_empty  (fifo_empty),
        .rows_loaded (rows_loaded),
        .issue_done  (issue_done),
        .retire_done (retire_done),
        .run_start   (run_start),
        .fifo_pop    (fifo_pop),
        .act_ready   (act_ready),
        .busy        (busy),
        .done        (done)
    );

    run_counter i_run_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .run_start   (run_start),
        .num_vectors (cfg.num_vectors),
        .row_step    (fifo_pop),
        .issue       (act_issue),
        .retire      (result_valid),
        .row_idx     (row_idx),
        .rows_loaded (rows_loaded),
        .issue_done  (issue_done),
        .retire_done (retire_done)
    );

    // Popped row lands in the row that the counter points at
    pe_array i_pe_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_en    (fifo_pop),
        .load_row   (row_idx),
        .weight_row (head_row),
        .issue      (act_issue),
        .act_vec    (act_data),
        .results    (result_data),
        .out_valid  (result_valid)
    );

endmodule

`default_nettype wire

//--- verilog/gemm_sequencer.sv
// Only MODE_GEMM with a nonzero count starts a run; start is ignored outside IDLE
`default_nettype none

module gemm_sequencer (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start,
    input  wire systolic_pkg::run_cfg_t cfg,
    input  wire                         fifo_empty,
    input  wire                         rows_loaded,
    input  wire                         issue_done,
    input  wire                         retire_done,
    output logic                        run_start,
    output logic                        fifo_pop,
    output logic                        act_ready,
    output logic                        busy,
    output logic                        done
);

    systolic_pkg::state_t state_q;
    systolic_pkg::state_t state_d;

    // ------------------------------------------------------------------
    // Run acceptance
    // ------------------------------------------------------------------
    assign run_start = (state_q == systolic_pkg::IDLE) && start
                       && (cfg.mode == systolic_pkg::MODE_GEMM)
                       && (cfg.num_vectors != '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            systolic_pkg::IDLE: begin
                if (run_start) begin
                    state_d = systolic_pkg::LOAD;
                end
            end
            systolic_pkg::LOAD: begin
                if (rows_loaded) begin
                    state_d = systolic_pkg::COMPUTE;
                end
            end
            systolic_pkg::COMPUTE: begin
                if (issue_done) begin
                    state_d = systolic_pkg::DRAIN;
                end
            end
            systolic_pkg::DRAIN: begin
                if (retire_done) begin
                    state_d = systolic_pkg::DONE;
                end
            end
            default: state_d = systolic_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= systolic_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Pop stalls on an empty FIFO and stops once all rows are in
    assign fifo_pop  = (state_q == systolic_pkg::LOAD) && !rows_loaded && !fifo_empty;
    // Drops right after the last accepted vector
    assign act_ready = (state_q == systolic_pkg::COMPUTE) && !issue_done;
    assign busy      = (state_q != systolic_pkg::IDLE);
    assign done      = (state_q == systolic_pkg::DONE);

endmodule

`default_nettype wire

//--- verilog/run_counter.sv
// Targets are latched at run_start; flags are only meaningful within a run
`default_nettype none

module run_counter (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   run_start,
    input  wire [systolic_pkg::NUM_VEC_WIDTH-1:0] num_vectors,
    input  wire                                   row_step,
    input  wire                                   issue,
    input  wire                                   retire,
    output systolic_pkg::row_idx_t                row_idx,
    output logic                                  rows_loaded,
    output logic                                  issue_done,
    output logic                                  retire_done
);

    logic [systolic_pkg::NUM_VEC_WIDTH-1:0]     target_q;
    logic [$clog2(systolic_pkg::ARRAY_DIM+1)-1:0] row_cnt_q;
    logic [systolic_pkg::NUM_VEC_WIDTH-1:0]     issue_cnt_q;
    logic [systolic_pkg::NUM_VEC_WIDTH-1:0]     retire_cnt_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            target_q     <= '0;
            row_cnt_q    <= '0;
            issue_cnt_q  <= '0;
            retire_cnt_q <= '0;
        end else if (run_start) begin
            target_q     <= num_vectors;
            row_cnt_q    <= '0;
            issue_cnt_q  <= '0;
            retire_cnt_q <= '0;
        end else begin
            if (row_step && !rows_loaded) begin
                row_cnt_q <= row_cnt_q + 1'b1;
            end
            if (issue) begin
                issue_cnt_q <= issue_cnt_q + 1'b1;
            end
            if (retire) begin
                retire_cnt_q <= retire_cnt_q + 1'b1;
            end
        end
    end

    // Flags straight from the registers
    assign row_idx     = row_cnt_q[$clog2(systolic_pkg::ARRAY_DIM)-1:0];
    assign rows_loaded = (row_cnt_q == systolic_pkg::ARRAY_DIM);
    assign issue_done  = (issue_cnt_q == target_q);
    assign retire_done = (retire_cnt_q == target_q);

endmodule

`default_nettype wire

//--- verilog/weight_fifo.sv
// Depth must be a power of two; a push while full and a pop while empty are dropped
`default_nettype none

module weight_fifo (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     push,
    input  wire systolic_pkg::vec_t push_row,
    output logic                    full,
    input  wire                     pop,
    output systolic_pkg::vec_t      head_row,
    output logic                    empty
);

    systolic_pkg::vec_t mem [systolic_pkg::WEIGHT_FIFO_DEPTH];

    logic [$clog2(systolic_pkg::WEIGHT_FIFO_DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(systolic_pkg::WEIGHT_FIFO_DEPTH)-1:0]   rd_ptr_q;
    logic [$clog2(systolic_pkg::WEIGHT_FIFO_DEPTH+1)-1:0] count_q;
    logic do_push;
    logic do_pop;

    assign full     = (count_q == systolic_pkg::WEIGHT_FIFO_DEPTH);
    assign empty    = (count_q == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign head_row = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_row;
        end
    end

    // Pointers wrap on their own
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- pe_array/pe_array.sv
// Results are valid only with out_valid; data between vectors is not meaningful
`default_nettype none

module pe_array (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          load_en,
    input  wire systolic_pkg::row_idx_t  load_row,
    input  wire systolic_pkg::vec_t      weight_row,
    input  wire                          issue,
    input  wire systolic_pkg::vec_t      act_vec,
    output systolic_pkg::result_vec_t    results,
    output logic                         out_valid
);

    wire systolic_pkg::elem_t act_h  [systolic_pkg::ARRAY_DIM][systolic_pkg::ARRAY_DIM+1];
    wire systolic_pkg::acc_t  psum_v [systolic_pkg::ARRAY_DIM+1][systolic_pkg::ARRAY_DIM];
    wire systolic_pkg::vec_t        act_gated;
    wire systolic_pkg::result_vec_t aligned;

    logic [systolic_pkg::PIPE_LATENCY-1:0] valid_sr;

    // Idle cycles push zeros through the grid
    assign act_gated = issue ? act_vec : '0;

    // ------------------------------------------------------------------
    // Input skew delays row r by r cycles
    // ------------------------------------------------------------------
    for (genvar r = 0; r < systolic_pkg::ARRAY_DIM; r++) begin : g_skew
        if (r == 0) begin : g_direct
            assign act_h[r][0] = act_gated[r];
        end else begin : g_delay
            systolic_pkg::elem_t dly_q [r];
            always_ff @(posedge clk) begin
                dly_q[0] <= act_gated[r];
                for (int i = 1; i < r; i++) begin
                    dly_q[i] <= dly_q[i-1];
                end
            end
            assign act_h[r][0] = dly_q[r-1];
        end
    end

    // ------------------------------------------------------------------
    // Cell grid where activations move right and sums move down
    // ------------------------------------------------------------------
    for (genvar c = 0; c < systolic_pkg::ARRAY_DIM; c++) begin : g_top
        assign psum_v[0][c] = '0;
    end

    for (genvar r = 0; r < systolic_pkg::ARRAY_DIM; r++) begin : g_row
        wire row_load;
        assign row_load = load_en && (load_row == r);
        for (genvar c = 0; c < systolic_pkg::ARRAY_DIM; c++) begin : g_col
            systolic_pe i_pe (
                .clk       (clk),
                .rst_n     (rst_n),
                .load_en   (row_load),
                .weight_in (weight_row[c]),
                .act_in    (act_h[r][c]),
                .psum_in   (psum_v[r][c]),
                .act_out   (act_h[r][c+1]),
                .psum_out  (psum_v[r+1][c])
            );
        end
    end

    // Output deskew delays column c by ARRAY_DIM-1-c cycles
    for (genvar c = 0; c < systolic_pkg::ARRAY_DIM; c++) begin : g_deskew
        if (c == systolic_pkg::ARRAY_DIM - 1) begin : g_direct
            assign aligned[c] = psum_v[systolic_pkg::ARRAY_DIM][c];
        end else begin : g_delay
            systolic_pkg::acc_t dly_q [systolic_pkg::ARRAY_DIM-1-c];
            always_ff @(posedge clk) begin
                dly_q[0] <= psum_v[systolic_pkg::ARRAY_DIM][c];
                for (int i = 1; i < systolic_pkg::ARRAY_DIM - 1 - c; i++) begin
                    dly_q[i] <= dly_q[i-1];
                end
            end
            assign aligned[c] = dly_q[systolic_pkg::ARRAY_DIM-2-c];
        end
    end

    always_ff @(posedge clk) begin
        results <= aligned;
    end

    // Issue bit follows its vector through the pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[systolic_pkg::PIPE_LATENCY-2:0], issue};
        end
    end

    assign out_valid = valid_sr[systolic_pkg::PIPE_LATENCY-1];

endmodule

`default_nettype wire

//--- pe_array/systolic_pe.sv
// Weight register has no reset and holds an unknown value until the first load
`default_nettype none

module systolic_pe (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  load_en,
    input  wire systolic_pkg::elem_t weight_in,
    input  wire systolic_pkg::elem_t act_in,
    input  wire systolic_pkg::acc_t  psum_in,
    output systolic_pkg::elem_t  act_out,
    output systolic_pkg::acc_t   psum_out
);

    systolic_pkg::elem_t weight_q;
    systolic_pkg::acc_t  product;
    systolic_pkg::acc_t  sum;
    logic                ovf_pos;
    logic                ovf_neg;

    // Stationary weight
    always_ff @(posedge clk) begin
        if (load_en) begin
            weight_q <= weight_in;
        end
    end

    // Product is sign extended to the accumulator width
    assign product = weight_q * act_in;
    assign sum     = psum_in + product;

    // Same operand signs and a flipped result sign mean overflow
    assign ovf_pos = !psum_in[systolic_pkg::ACC_WIDTH-1] && !product[systolic_pkg::ACC_WIDTH-1]
                     && sum[systolic_pkg::ACC_WIDTH-1];
    assign ovf_neg = psum_in[systolic_pkg::ACC_WIDTH-1] && product[systolic_pkg::ACC_WIDTH-1]
                     && !sum[systolic_pkg::ACC_WIDTH-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_out  <= '0;
            psum_out <= '0;
        end else begin
            act_out <= act_in;
            if (ovf_pos) begin
                psum_out <= systolic_pkg::ACC_MAX;
            end else if (ovf_neg) begin
                psum_out <= systolic_pkg::ACC_MIN;
            end else begin
                psum_out <= sum;
            end
        end
    end

endmodule

`default_nettype wire

//--- common/systolic_pkg.sv
// Sizes are fixed for a 4x4 INT8 array; PIPE_LATENCY and row_idx_t follow ARRAY_DIM
`default_nettype none

package systolic_pkg;

    // ------------------------------------------------------------------
    // Array and datapath sizes
    // ------------------------------------------------------------------
    localparam int ARRAY_DIM         = 4;
    localparam int DATA_WIDTH        = 8;
    localparam int ACC_WIDTH         = 32;
    localparam int WEIGHT_FIFO_DEPTH = 8;

    // Skew, grid hops, deskew and the output register together
    localparam int PIPE_LATENCY      = 2 * ARRAY_DIM;

    // Run configuration fields
    localparam int MODE_WIDTH        = 4;
    localparam int NUM_VEC_WIDTH     = 16;
    localparam logic [MODE_WIDTH-1:0] MODE_GEMM = 4'hF;

    // ------------------------------------------------------------------
    // Element and vector types
    // ------------------------------------------------------------------
    typedef logic signed [DATA_WIDTH-1:0] elem_t;
    typedef elem_t [ARRAY_DIM-1:0]        vec_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;
    typedef acc_t [ARRAY_DIM-1:0]         result_vec_t;

    typedef logic [$clog2(ARRAY_DIM)-1:0] row_idx_t;

    // Saturation limits of the accumulator
    localparam acc_t ACC_MAX = {1'b0, {(ACC_WIDTH-1){1'b1}}};
    localparam acc_t ACC_MIN = {1'b1, {(ACC_WIDTH-1){1'b0}}};

    typedef struct packed {
        logic [MODE_WIDTH-1:0]    mode;
        logic [NUM_VEC_WIDTH-1:0] num_vectors;
    } run_cfg_t;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        COMPUTE,
        DRAIN,
        DONE
    } state_t;

endpackage

`default_nettype wire
